// ==== include/rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Reorder buffer geometry
`define ROB_SIZE 8
`define ROB_IDX_SIZE 3  // log2 of ROB_SIZE

// Data path
`define GPR_SIZE 32
`define GPR_IDX_SIZE 4  // 16 architectural registers

// Condition flags
`define NZCV_SIZE 4

`endif

// ==== logic/isa_pkg.sv ====
package isa_pkg;

  // Opcode in bits 31:28 picks the view
  localparam logic [3:0] OPC_ALU = 4'b0001;
  localparam logic [3:0] OPC_BCOND = 4'b0101;

  // One instruction word, two decodings
  typedef union packed {
    // ALU format
    struct packed {
      logic [3:0] opcode;
      logic [3:0] rd;        // Destination register
      logic set_nzcv;        // Write flags on commit
      logic [3:0] rn;        // Source fields, read by the FUs
      logic [3:0] rm;
      logic [14:0] unused;
    } alu;
    // Conditional branch format
    struct packed {
      logic [3:0] opcode;
      logic [3:0] cond;      // ARM condition code
      logic [23:0] offset;   // Target offset, resolved by the FU
    } branch;
  } inst_word_u;

  // Condition code encodings
  localparam logic [3:0] COND_EQ = 4'h0;
  localparam logic [3:0] COND_NE = 4'h1;
  localparam logic [3:0] COND_CS = 4'h2;
  localparam logic [3:0] COND_CC = 4'h3;
  localparam logic [3:0] COND_MI = 4'h4;
  localparam logic [3:0] COND_PL = 4'h5;
  localparam logic [3:0] COND_VS = 4'h6;
  localparam logic [3:0] COND_VC = 4'h7;
  localparam logic [3:0] COND_HI = 4'h8;
  localparam logic [3:0] COND_LS = 4'h9;
  localparam logic [3:0] COND_GE = 4'ha;
  localparam logic [3:0] COND_LT = 4'hb;
  localparam logic [3:0] COND_GT = 4'hc;
  localparam logic [3:0] COND_LE = 4'hd;
  localparam logic [3:0] COND_AL = 4'he;

endpackage

// ==== logic/cond_pkg.sv ====
`include "rob_defs.svh"

package cond_pkg;

  // Flag positions inside NZCV
  localparam int NZCV_N_BIT = 3;
  localparam int NZCV_Z_BIT = 2;
  localparam int NZCV_C_BIT = 1;
  localparam int NZCV_V_BIT = 0;

  function automatic logic flag_n(input logic [`NZCV_SIZE-1:0] nzcv);
    return nzcv[NZCV_N_BIT];
  endfunction

  function automatic logic flag_z(input logic [`NZCV_SIZE-1:0] nzcv);
    return nzcv[NZCV_Z_BIT];
  endfunction

  function automatic logic flag_c(input logic [`NZCV_SIZE-1:0] nzcv);
    return nzcv[NZCV_C_BIT];
  endfunction

  function automatic logic flag_v(input logic [`NZCV_SIZE-1:0] nzcv);
    return nzcv[NZCV_V_BIT];
  endfunction

  // ARM condition test
  function automatic logic cond_holds(input logic [3:0] cond,
                                      input logic [`NZCV_SIZE-1:0] nzcv);
    logic n;
    logic z;
    logic c;
    logic v;
    logic res;
    n = flag_n(nzcv);
    z = flag_z(nzcv);
    c = flag_c(nzcv);
    v = flag_v(nzcv);
    case (cond)
      4'h0: res = z;                     // EQ
      4'h1: res = !z;                    // NE
      4'h2: res = c;                     // CS
      4'h3: res = !c;                    // CC
      4'h4: res = n;                     // MI
      4'h5: res = !n;                    // PL
      4'h6: res = v;                     // VS
      4'h7: res = !v;                    // VC
      4'h8: res = c && !z;               // HI
      4'h9: res = !c || z;               // LS
      4'ha: res = (n == v);              // GE
      4'hb: res = (n != v);              // LT
      4'hc: res = !z && (n == v);        // GT
      4'hd: res = z || (n != v);         // LE
      default: res = 1'b1;               // AL, and 4'hf behaves the same
    endcase
    return res;
  endfunction

endpackage

// ==== logic/dispatch_decoder.sv ====
`timescale 1ns/10ps
`include "rob_defs.svh"

module dispatch_decoder (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic                     inst_valid,
  input  isa_pkg::inst_word_u      inst_word,
  input  logic                     full,
  output logic                     alloc_req,
  output logic [`GPR_IDX_SIZE-1:0] alloc_gpr,
  output logic                     alloc_set_nzcv,
  output logic                     alloc_is_branch,
  output logic [3:0]               alloc_cond
);
  import isa_pkg::*;

  logic                     dec_known;
  logic                     dec_is_branch;
  logic [`GPR_IDX_SIZE-1:0] dec_gpr;
  logic                     dec_set_nzcv;
  logic [3:0]               dec_cond;
  logic                     accept;

  // Opcode first, then the matching view
  always_comb begin
    dec_known     = 1'b0;
    dec_is_branch = 1'b0;
    dec_gpr       = '0;
    dec_set_nzcv  = 1'b0;
    dec_cond      = COND_AL;
    case (inst_word.alu.opcode)
      OPC_ALU: begin
        dec_known    = 1'b1;
        dec_gpr      = inst_word.alu.rd;
        dec_set_nzcv = inst_word.alu.set_nzcv;
      end
      OPC_BCOND: begin
        dec_known     = 1'b1;
        dec_is_branch = 1'b1;  // No register write
        dec_cond      = inst_word.branch.cond;
      end
      default: dec_known = 1'b0;  // Unknown opcodes dropped
    endcase
  end

  assign accept = inst_valid && !full && dec_known;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      alloc_req <= 1'b0;
    end else begin
      alloc_req <= accept;  // One-cycle request
    end
  end

  always_ff @(posedge in_clk) begin
    if (accept) begin
      alloc_gpr       <= dec_gpr;
      alloc_set_nzcv  <= dec_set_nzcv;
      alloc_is_branch <= dec_is_branch;
      alloc_cond      <= dec_cond;
    end
  end

endmodule

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/10ps
`include "rob_defs.svh"

module reorder_buffer (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  // Allocation from dispatch
  input  logic                     alloc_req,
  input  logic [`GPR_IDX_SIZE-1:0] alloc_gpr,
  input  logic                     alloc_set_nzcv,
  input  logic                     alloc_is_branch,
  input  logic [3:0]               alloc_cond,
  output logic [`ROB_IDX_SIZE-1:0] alloc_index,
  output logic                     full,
  // Completion from the FUs
  input  logic                     fu_done,
  input  logic [`ROB_IDX_SIZE-1:0] fu_rob_index,
  input  logic [`GPR_SIZE-1:0]     fu_value,
  input  logic [`NZCV_SIZE-1:0]    fu_nzcv,
  // Head of the buffer, to commit
  output logic                     head_valid,
  output logic [`GPR_IDX_SIZE-1:0] head_gpr,
  output logic [`GPR_SIZE-1:0]     head_value,
  output logic [`NZCV_SIZE-1:0]    head_nzcv,
  output logic                     head_set_nzcv,
  output logic                     head_is_branch,
  output logic [3:0]               head_cond,
  input  logic                     flush
);

  // Full leaves room for the request already in flight
  localparam logic [`ROB_IDX_SIZE:0] FULL_LEVEL = `ROB_SIZE - 1;

  // Per-entry control bits
  logic [`ROB_SIZE-1:0] valid;
  logic [`ROB_SIZE-1:0] done;

  // Per-entry payload
  logic [`GPR_IDX_SIZE-1:0] gpr_mem      [`ROB_SIZE];
  logic                     set_nzcv_mem [`ROB_SIZE];
  logic                     branch_mem   [`ROB_SIZE];
  logic [3:0]               cond_mem     [`ROB_SIZE];
  logic [`GPR_SIZE-1:0]     value_mem    [`ROB_SIZE];
  logic [`NZCV_SIZE-1:0]    nzcv_mem     [`ROB_SIZE];

  logic [`ROB_IDX_SIZE-1:0] head;   // Oldest entry
  logic [`ROB_IDX_SIZE-1:0] tail;   // Next free slot
  logic [`ROB_IDX_SIZE:0]   count;
  logic [`ROB_IDX_SIZE:0]   count_next;
  logic                     complete_ok;

  assign alloc_index = tail;
  assign full        = (count >= FULL_LEVEL);
  assign complete_ok = fu_done && valid[fu_rob_index];  // Stale indices ignored

  // Head is ready once its result is in
  assign head_valid     = valid[head] && done[head];
  assign head_gpr       = gpr_mem[head];
  assign head_value     = value_mem[head];
  assign head_nzcv      = nzcv_mem[head];
  assign head_set_nzcv  = set_nzcv_mem[head];
  assign head_is_branch = branch_mem[head];
  assign head_cond      = cond_mem[head];

  always_comb begin
    count_next = count;
    if (alloc_req) count_next = count_next + 1'b1;
    if (head_valid) count_next = count_next - 1'b1;
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      valid <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      // Mispredict, drop every entry including a new allocation
      valid <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc_req) begin
        valid[tail] <= 1'b1;
        done[tail]  <= 1'b0;
        tail        <= tail + 1'b1;
      end
      if (complete_ok) done[fu_rob_index] <= 1'b1;
      if (head_valid) begin  // Pop in program order
        valid[head] <= 1'b0;
        done[head]  <= 1'b0;
        head        <= head + 1'b1;
      end
      count <= count_next;
    end
  end

  always_ff @(posedge in_clk) begin
    if (alloc_req) begin
      gpr_mem[tail]      <= alloc_gpr;
      set_nzcv_mem[tail] <= alloc_set_nzcv;
      branch_mem[tail]   <= alloc_is_branch;
      cond_mem[tail]     <= alloc_cond;
    end
    if (complete_ok) begin
      value_mem[fu_rob_index] <= fu_value;
      nzcv_mem[fu_rob_index]  <= fu_nzcv;
    end
  end

endmodule

// ==== logic/commit_unit.sv ====
`timescale 1ns/10ps
`include "rob_defs.svh"

module commit_unit (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic                     head_valid,
  input  logic [`GPR_IDX_SIZE-1:0] head_gpr,
  input  logic [`GPR_SIZE-1:0]     head_value,
  input  logic [`NZCV_SIZE-1:0]    head_nzcv,
  input  logic                     head_set_nzcv,
  input  logic                     head_is_branch,
  input  logic [3:0]               head_cond,
  output logic                     flush,
  output logic                     commit_valid,
  output logic [`GPR_IDX_SIZE-1:0] commit_gpr,
  output logic [`GPR_SIZE-1:0]     commit_value,
  output logic [`NZCV_SIZE-1:0]    commit_nzcv,
  output logic                     redirect,
  output logic [`GPR_SIZE-1:0]     redirect_pc
);
  import cond_pkg::*;

  localparam int GPR_COUNT = 1 << `GPR_IDX_SIZE;

  logic [`GPR_SIZE-1:0]  arch_regs [GPR_COUNT];  // Architectural register file
  logic [`NZCV_SIZE-1:0] arch_nzcv;
  logic [`NZCV_SIZE-1:0] nzcv_next;
  logic                  write_en;

  // Predicted not-taken, so a holding condition is a mispredict
  assign flush     = head_valid && head_is_branch && cond_holds(head_cond, arch_nzcv);
  assign write_en  = head_valid && !head_is_branch;
  assign nzcv_next = head_set_nzcv ? head_nzcv : arch_nzcv;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      for (int i = 0; i < GPR_COUNT; i++) arch_regs[i] <= '0;
      arch_nzcv    <= '0;
      commit_valid <= 1'b0;
      redirect     <= 1'b0;
    end else begin
      if (write_en) begin
        arch_regs[head_gpr] <= head_value;
        arch_nzcv           <= nzcv_next;
      end
      commit_valid <= write_en;  // Branches never commit
      redirect     <= flush;
    end
  end

  always_ff @(posedge in_clk) begin
    if (write_en) begin
      commit_gpr   <= head_gpr;
      commit_value <= head_value;
      commit_nzcv  <= nzcv_next;  // Flags after this write
    end
    if (flush) redirect_pc <= head_value;  // FU supplies the target
  end

endmodule

// ==== logic/rob_core.sv ====
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_core (
  input  logic                     in_clk,
  input  logic                     in_rst_n,
  input  logic                     inst_valid,
  input  isa_pkg::inst_word_u      inst_word,
  output logic                     full,
  output logic                     alloc_req,
  output logic [`ROB_IDX_SIZE-1:0] alloc_index,
  input  logic                     fu_done,
  input  logic [`ROB_IDX_SIZE-1:0] fu_rob_index,
  input  logic [`GPR_SIZE-1:0]     fu_value,
  input  logic [`NZCV_SIZE-1:0]    fu_nzcv,
  output logic                     commit_valid,
  output logic [`GPR_IDX_SIZE-1:0] commit_gpr,
  output logic [`GPR_SIZE-1:0]     commit_value,
  output logic [`NZCV_SIZE-1:0]    commit_nzcv,
  output logic                     redirect,
  output logic [`GPR_SIZE-1:0]     redirect_pc
);

  // Decoder to buffer
  logic [`GPR_IDX_SIZE-1:0] alloc_gpr;
  logic                     alloc_set_nzcv;
  logic                     alloc_is_branch;
  logic [3:0]               alloc_cond;

  // Buffer head to commit
  logic                     head_valid;
  logic [`GPR_IDX_SIZE-1:0] head_gpr;
  logic [`GPR_SIZE-1:0]     head_value;
  logic [`NZCV_SIZE-1:0]    head_nzcv;
  logic                     head_set_nzcv;
  logic                     head_is_branch;
  logic [3:0]               head_cond;
  logic                     flush;

  dispatch_decoder u_decoder (
    .in_clk, .in_rst_n, .inst_valid, .inst_word, .full,
    .alloc_req, .alloc_gpr, .alloc_set_nzcv, .alloc_is_branch, .alloc_cond
  );

  reorder_buffer u_rob (
    .in_clk, .in_rst_n,
    .alloc_req, .alloc_gpr, .alloc_set_nzcv, .alloc_is_branch, .alloc_cond,
    .alloc_index, .full,
    .fu_done, .fu_rob_index, .fu_value, .fu_nzcv,
    .head_valid, .head_gpr, .head_value, .head_nzcv, .head_set_nzcv,
    .head_is_branch, .head_cond, .flush
  );

  commit_unit u_commit (
    .in_clk, .in_rst_n,
    .head_valid, .head_gpr, .head_value, .head_nzcv, .head_set_nzcv,
    .head_is_branch, .head_cond, .flush,
    .commit_valid, .commit_gpr, .commit_value, .commit_nzcv,
    .redirect, .redirect_pc
  );

endmodule

// ==== tests/rob_core_assert.sv ====
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_core_assert (
  input logic                     in_clk,
  input logic                     in_rst_n,
  input logic                     alloc_req,
  input logic                     head_valid,
  input logic                     flush,
  input logic                     fu_done,
  input logic [`ROB_IDX_SIZE-1:0] fu_rob_index,
  input logic [`ROB_IDX_SIZE-1:0] head,
  input logic [`ROB_IDX_SIZE:0]   count
);

  // A waiting head only turns ready through a completion aimed at it
  head_done_check: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    $rose(head_valid) |-> $past(fu_done && (fu_rob_index == head)))
    else $error("head_valid raised for an entry that was never completed");

  alloc_room_check: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    alloc_req |-> (count < `ROB_SIZE))  // Full must stop dispatch early enough
    else $error("allocation arrived with no free entry left");

  // Flush empties the buffer
  flush_clear_check: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    flush |=> !head_valid)
    else $error("head_valid still high one cycle after a flush");

endmodule

bind reorder_buffer rob_core_assert u_assert (
  .in_clk, .in_rst_n, .alloc_req, .head_valid, .flush,
  .fu_done, .fu_rob_index, .head,
  .count
);

// ==== tests/tb_rob_core.sv ====
`timescale 1ns/10ps
`include "rob_defs.svh"

module tb_rob_core;
  import isa_pkg::*;
  import cond_pkg::*;

  localparam int NUM_ROWS = 22;
  localparam int NUM_GROUPS = 4;
  localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 100;
  localparam int GPR_COUNT = 1 << `GPR_IDX_SIZE;

  logic                     in_clk;
  logic                     in_rst_n;
  logic                     inst_valid;
  inst_word_u               inst_word;
  logic                     full;
  logic                     alloc_req;
  logic [`ROB_IDX_SIZE-1:0] alloc_index;
  logic                     fu_done;
  logic [`ROB_IDX_SIZE-1:0] fu_rob_index;
  logic [`GPR_SIZE-1:0]     fu_value;
  logic [`NZCV_SIZE-1:0]    fu_nzcv;
  logic                     commit_valid;
  logic [`GPR_IDX_SIZE-1:0] commit_gpr;
  logic [`GPR_SIZE-1:0]     commit_value;
  logic [`NZCV_SIZE-1:0]    commit_nzcv;
  logic                     redirect;
  logic [`GPR_SIZE-1:0]     redirect_pc;

  // One row per instruction
  inst_word_u            row_word  [NUM_ROWS];
  logic [`GPR_SIZE-1:0]  row_value [NUM_ROWS];
  logic [`NZCV_SIZE-1:0] row_nzcv  [NUM_ROWS];
  int grp_start [NUM_GROUPS] = '{0, 6, 10, 12};
  int grp_len   [NUM_GROUPS] = '{6, 4, 2, 10};  // Last group overfills the buffer

  // Reference model and the events it predicts
  logic [`GPR_SIZE-1:0]     model_regs [GPR_COUNT];
  logic [`NZCV_SIZE-1:0]    model_nzcv;
  logic                     model_flushed;
  logic [`GPR_IDX_SIZE-1:0] exp_gpr_q [$];
  logic [`GPR_SIZE-1:0]     exp_value_q [$];
  logic [`NZCV_SIZE-1:0]    exp_nzcv_q [$];
  logic [`GPR_SIZE-1:0]     exp_pc_q [$];
  logic [`ROB_IDX_SIZE-1:0] alloc_idx_q [$];
  int                       alloc_count;
  logic                     full_seen;
  logic [31:0]              rng_state;
  int                       errors = 0;
  int                       cycles;

  rob_core DUT (.*);

  initial begin
    in_clk = 1'b0;
    forever #5 in_clk = ~in_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic inst_word_u alu_word(input logic [3:0] rd, input logic set_flags);
    inst_word_u w;
    w = '0;
    w.alu.opcode = OPC_ALU;
    w.alu.rd = rd;
    w.alu.set_nzcv = set_flags;
    return w;
  endfunction

  function automatic inst_word_u branch_word(input logic [3:0] cond);
    inst_word_u w;
    w = '0;
    w.branch.opcode = OPC_BCOND;
    w.branch.cond = cond;
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic set_row(input int i, input inst_word_u w, input logic [31:0] value,
                         input logic [3:0] nzcv);
    row_word[i] = w;
    row_value[i] = value;
    row_nzcv[i] = nzcv;
  endtask

  task automatic fill_table();
    set_row(0, alu_word(4'd1, 1'b1), 32'h11, 4'b0100);   // Sets Z
    set_row(1, alu_word(4'd2, 1'b0), 32'h22, 4'b1111);   // Flags ignored
    set_row(2, branch_word(COND_NE), 32'h200, 4'b0000);  // Not taken
    set_row(3, alu_word(4'd3, 1'b1), 32'h33, 4'b1000);
    set_row(4, alu_word(4'd4, 1'b0), 32'h44, 4'b0000);
    set_row(5, branch_word(COND_EQ), 32'h300, 4'b0000);  // Not taken, Z clear
    set_row(6, alu_word(4'd5, 1'b1), 32'h55, 4'b0010);   // Sets C
    set_row(7, branch_word(COND_CS), 32'h400, 4'b0000);  // Taken, flushes the rest
    set_row(8, alu_word(4'd6, 1'b1), 32'h66, 4'b1111);
    set_row(9, alu_word(4'd7, 1'b0), 32'h77, 4'b0000);
    set_row(10, alu_word(4'd8, 1'b1), 32'h88, 4'b0001);
    set_row(11, alu_word(4'd9, 1'b0), 32'h99, 4'b0000);
    for (int i = 12; i < NUM_ROWS; i++) begin
      set_row(i, alu_word(i[3:0], i[0]), 32'h1000 + i, i[3:0]);
    end
  endtask

  // Program-order walk, stops at the first taken branch
  task automatic predict(input int start, input int live);
    logic taken;
    taken = 1'b0;
    for (int i = start; i < start + live && !taken; i++) begin
      if (row_word[i].alu.opcode == OPC_BCOND) begin
        taken = cond_holds(row_word[i].branch.cond, model_nzcv);
        if (taken) exp_pc_q.push_back(row_value[i]);
      end else begin
        if (row_word[i].alu.set_nzcv) model_nzcv = row_nzcv[i];
        model_regs[row_word[i].alu.rd] = row_value[i];
        exp_gpr_q.push_back(row_word[i].alu.rd);
        exp_value_q.push_back(row_value[i]);
        exp_nzcv_q.push_back(model_nzcv);
      end
    end
    model_flushed = taken;
  endtask

  task automatic dispatch_rows(input int start, input int len);
    for (int i = start; i < start + len; i++) begin
      @(posedge in_clk);
      #1;
      inst_valid = 1'b1;
      inst_word = row_word[i];
    end
    @(posedge in_clk);
    #1;
    inst_valid = 1'b0;
    repeat (2) @(negedge in_clk);  // Last request has reached the buffer
  endtask

  task automatic complete_rows(input int start, input int live);
    int order [`ROB_SIZE];
    int j;
    int tmp;
    for (int i = 0; i < live; i++) order[i] = i;
    for (int i = live - 1; i > 0; i--) begin  // Fisher-Yates shuffle
      rng_state = xorshift(rng_state);
      j = rng_state % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < live; i++) begin
      @(posedge in_clk);
      #1;
      fu_done = 1'b1;
      fu_rob_index = alloc_idx_q[order[i]];
      fu_value = row_value[start + order[i]];
      fu_nzcv = row_nzcv[start + order[i]];
    end
    @(posedge in_clk);
    #1;
    fu_done = 1'b0;
  endtask

  task automatic run_group(input int g);
    int start;
    int len;
    int live;
    logic was_cleared;
    start = grp_start[g];
    len = grp_len[g];
    live = (len < `ROB_SIZE) ? len : `ROB_SIZE;  // Empty buffer holds at most ROB_SIZE
    was_cleared = model_flushed;
    alloc_idx_q.delete();
    alloc_count = 0;
    full_seen = 1'b0;
    predict(start, live);
    dispatch_rows(start, len);
    check("alloc_req count", alloc_count, live);
    if (len > live) check("full", full_seen, 1'b1);
    if (was_cleared) check("alloc_index", alloc_idx_q[0], '0);
    complete_rows(start, live);
    while (exp_value_q.size() != 0 || exp_pc_q.size() != 0) @(negedge in_clk);
    repeat (4) @(negedge in_clk);  // Room for stray commits or redirects
  endtask

  task automatic check_reset_state();
    check("alloc_req", alloc_req, 1'b0);
    check("full", full, 1'b0);
    check("commit_valid", commit_valid, 1'b0);
    check("redirect", redirect, 1'b0);
  endtask

  // Flushed rows must leave no trace in the register file
  task automatic check_reg_file();
    for (int i = 0; i < GPR_COUNT; i++) begin
      check($sformatf("arch_regs[%0d]", i), DUT.u_commit.arch_regs[i], model_regs[i]);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge in_clk) begin
    if (in_rst_n) begin
      if (alloc_req) begin
        alloc_idx_q.push_back(alloc_index);
        alloc_count++;
      end
      if (full) full_seen = 1'b1;
      if (commit_valid) begin
        if (exp_value_q.size() == 0) begin
          $display("commit at %0t ns with no instruction left to retire", $time);
          errors++;
        end else begin
          check("commit_gpr", commit_gpr, exp_gpr_q.pop_front());
          check("commit_value", commit_value, exp_value_q.pop_front());
          check("commit_nzcv", commit_nzcv, exp_nzcv_q.pop_front());
        end
      end
      if (redirect) begin
        if (exp_pc_q.size() == 0) begin
          $display("redirect at %0t ns that no taken branch explains", $time);
          errors++;
        end else begin
          check("redirect_pc", redirect_pc, exp_pc_q.pop_front());
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge in_clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("tests failed");
    $finish;
  end

  initial begin
    rng_state = 32'd41;
    foreach (model_regs[i]) model_regs[i] = '0;
    model_nzcv = '0;
    model_flushed = 1'b1;  // Reset leaves both pointers at zero
    in_rst_n = 1'b0;
    inst_valid = 1'b0;
    inst_word = '0;
    fu_done = 1'b0;
    fu_rob_index = '0;
    fu_value = '0;
    fu_nzcv = '0;
    fill_table();
    repeat (3) begin
      @(negedge in_clk);
      check_reset_state();
    end
    @(posedge in_clk);
    #1;
    in_rst_n = 1'b1;
    @(negedge in_clk);
    check_reset_state();
    for (int g = 0; g < NUM_GROUPS; g++) run_group(g);
    check_reg_file();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
logic/isa_pkg.sv
logic/cond_pkg.sv
logic/dispatch_decoder.sv
logic/reorder_buffer.sv
logic/commit_unit.sv
logic/rob_core.sv
tests/rob_core_assert.sv
tests/tb_rob_core.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = tb_rob_core
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for a pass"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
